// File: bench/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;

    import datapathPkg::*;

    localparam int DataWidth     = 32;
    localparam int TimeoutCycles = 3000; // Wide margin over the roughly 200 cycles of all tests
    localparam aluOpE AluOps [8] = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opNeg, opNot};

    logic                 Clock;
    logic                 rstN;
    logic [RegCount-1:0]  regIn;
    logic                 hiIn, loIn, pcIn, irIn, marIn, mdrIn, yIn, zIn;
    logic [SrcCount-1:0]  outSel;
    logic                 memRead;
    logic [DataWidth-1:0] memDataIn;
    logic [DataWidth-1:0] inPortData;
    aluOpE                aluOp;
    logic [DataWidth-1:0] busData;
    logic [DataWidth-1:0] marValue;
    logic [DataWidth-1:0] irValue;

    logic [31:0] rngState;
    int          errorCount = 0;
    int          checkCount = 0;
    int          errorsBefore = 0;
    int          cycleCount = 0;

    datapath #(.DataWidth(DataWidth)) i_dut (.*);

    initial Clock = 1'b0;
    always #5 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected results with A as the Y operand and B as the bus operand
    function automatic logic [31:0] expectedAlu(input aluOpE op, input logic [31:0] a,
                                                input logic [31:0] b);
        case (op)
            opAdd: return a + b;
            opSub: return a - b;
            opAnd: return a & b;
            opOr: return a | b;
            opShl: return a << b[4:0];
            opShr: return $unsigned($signed(a) >>> b[4:0]);
            opNeg: return 32'd0 - b;
            opNot: return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value = rngState;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic clearStrobes();
        regIn   = '0;
        {hiIn, loIn, pcIn, irIn, marIn, mdrIn, yIn, zIn} = '0;
        outSel  = '0;
        memRead = 1'b0;
        aluOp   = opAdd;
    endtask

    // Strobes drop on the falling edge that ends a control step
    task automatic nextCycle();
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic readBus(input int src, output logic [31:0] value);
        outSel[src] = 1'b1;
        #1;
        value = busData;
        nextCycle();
    endtask

    task automatic loadMdr(input logic [31:0] value);
        mdrIn     = 1'b1;
        memRead   = 1'b1;
        memDataIn = value;
        nextCycle();
    endtask

    task automatic loadReg(input int r, input logic [31:0] value);
        loadMdr(value);
        outSel[srcMdr] = 1'b1;
        regIn[r] = 1'b1;
        nextCycle();
    endtask

    // R2 into Y, then R3 on the bus into the ALU and Z
    task automatic aluOnOperands(input aluOpE op, input logic [31:0] a, input logic [31:0] b);
        loadReg(2, a);
        loadReg(3, b);
        outSel[srcR2] = 1'b1;
        yIn = 1'b1;
        nextCycle();
        outSel[srcR3] = 1'b1;
        aluOp = op;
        zIn = 1'b1;
        nextCycle();
    endtask

    task automatic endTest(input string name);
        $display("Test %s finished with %0d errors", name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    task automatic testResetState();
        logic [31:0] got;
        for (int src = 0; src < SrcCount; src++) begin
            readBus(src, got);
            checkValue($sformatf("busData source %0d", src), '0, got);
        end
        checkValue("marValue", '0, marValue);
        checkValue("irValue", '0, irValue);
        endTest("reset state");
    endtask

    task automatic testRegisterReadback();
        logic [31:0] values [18];
        logic [31:0] got;
        logic [31:0] prev;
        for (int i = 0; i < 18; i++) begin
            drawRandom(values[i]);
        end
        for (int r = 0; r < RegCount; r++) begin
            loadReg(r, values[r]);
        end
        loadMdr(values[16]);
        outSel[srcMdr] = 1'b1;
        hiIn = 1'b1;
        nextCycle();
        loadMdr(values[17]);
        outSel[srcMdr] = 1'b1;
        loIn = 1'b1;
        nextCycle();
        for (int i = 0; i < 18; i++) begin
            readBus(srcR0 + i, got); // HI and LO follow R15 in the strobe vector
            checkValue(i < 16 ? $sformatf("R%0d", i) : (i == 16 ? "HI" : "LO"), values[i], got);
        end
        prev = inPortData;
        drawRandom(inPortData);
        outSel[srcInPort] = 1'b1;
        #1;
        checkValue("busData port before sample", prev, busData);
        nextCycle();
        readBus(srcInPort, got);
        checkValue("busData port", inPortData, got);
        endTest("register readback");
    endtask

    task automatic testAluOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [31:0] got;
        foreach (AluOps[k]) begin
            drawRandom(a);
            drawRandom(b);
            expected = expectedAlu(AluOps[k], a, b);
            aluOnOperands(AluOps[k], a, b);
            outSel[srcZLow] = 1'b1;
            regIn[1] = 1'b1;
            nextCycle();
            readBus(srcR1, got);
            checkValue($sformatf("R1 %s", AluOps[k].name()), expected, got);
            readBus(srcZHigh, got);
            checkValue($sformatf("zHigh %s", AluOps[k].name()), {32{expected[31]}}, got);
        end
        endTest("ALU operations");
    endtask

    task automatic testMultiply();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        longint      product;
        for (int n = 0; n < 3; n++) begin
            drawRandom(a);
            drawRandom(b);
            product = longint'($signed(a)) * longint'($signed(b));
            aluOnOperands(opMul, a, b);
            outSel[srcZHigh] = 1'b1;
            hiIn = 1'b1;
            nextCycle();
            outSel[srcZLow] = 1'b1;
            loIn = 1'b1;
            nextCycle();
            readBus(srcHi, got);
            checkValue("HI product", product[63:32], got);
            readBus(srcLo, got);
            checkValue("LO product", product[31:0], got);
        end
        endTest("multiply");
    endtask

    task automatic testFetch();
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] got;
        drawRandom(pc);
        drawRandom(instr);
        loadMdr(pc);
        outSel[srcMdr] = 1'b1;
        pcIn = 1'b1;
        nextCycle();
        outSel[srcPc] = 1'b1; // T0
        marIn = 1'b1;
        aluOp = opInc;
        zIn = 1'b1;
        nextCycle();
        outSel[srcZLow] = 1'b1; // T1
        pcIn = 1'b1;
        mdrIn = 1'b1;
        memRead = 1'b1;
        memDataIn = instr;
        nextCycle();
        outSel[srcMdr] = 1'b1; // T2
        irIn = 1'b1;
        nextCycle();
        checkValue("marValue", pc, marValue);
        readBus(srcPc, got);
        checkValue("PC", pc + 32'd1, got);
        checkValue("irValue", instr, irValue);
        endTest("instruction fetch");
    endtask

    initial begin
        rngState   = 32'hd8b7;
        memDataIn  = '0;
        inPortData = '0;
        clearStrobes();
        rstN = 1'b0;
        repeat (10) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        testResetState();
        testRegisterReadback();
        testAluOps();
        testMultiply();
        testFetch();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/datapath_checker.sv
`timescale 1ns/1ps
`default_nettype none

module datapathChecker #(
    parameter int DataWidth = 32
) (
    input wire logic                               Clock,
    input wire logic                               rstN,
    input wire logic [datapathPkg::SrcCount-1:0]   outSel,
    input wire logic                               zIn,
    input wire logic [datapathPkg::AluOpWidth-1:0] aluOp,
    input wire logic [DataWidth-1:0]               busData
);

    import datapathPkg::*;

    // Single driver on the shared bus
    oneSource: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(outSel))
        else $error("outSel selects more than one bus source");

    knownOp: assert property (@(posedge Clock) disable iff (!rstN)
        zIn |-> (!$isunknown(aluOp) && aluOp <= opMul))
        else $error("Z loads with an unknown ALU operation");

    // Idle bus reads as zero
    idleBus: assert property (@(posedge Clock) disable iff (!rstN)
        (outSel == '0) |-> (busData == '0))
        else $error("busData is not zero with no source selected");

endmodule

bind datapath datapathChecker #(.DataWidth(DataWidth)) i_checker (
    .Clock(Clock), .rstN(rstN), .outSel(outSel),
    .zIn(zIn), .aluOp(aluCode), .busData(busData)
);

`default_nettype wire

// File: flist.f
rtl/datapathPkg.sv
rtl/memoryInterface.sv
rtl/registerBank.sv
rtl/aluStage.sv
rtl/busSelector.sv
rtl/datapath.sv
bench/datapath_checker.sv
bench/datapathTb.sv

// File: rtl/aluStage.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage #(
    parameter int DataWidth = 32
) (
    input  wire logic                              Clock,
    input  wire logic                              rstN,
    input  wire logic [DataWidth-1:0]              busData,
    input  wire logic                              yIn,
    input  wire logic                              zIn,
    input  wire logic [datapathPkg::AluOpWidth-1:0] aluOp,
    output logic      [DataWidth-1:0]              zHigh,
    output logic      [DataWidth-1:0]              zLow
);

    import datapathPkg::*;

    localparam int ShiftBits = $clog2(DataWidth);

    aluOpE                    op;
    logic [DataWidth-1:0]     yReg;
    logic [2*DataWidth-1:0]   zReg;
    logic [2*DataWidth-1:0]   aluResult;
    logic signed [2*DataWidth-1:0] aExt;
    logic signed [2*DataWidth-1:0] bExt;
    logic [ShiftBits-1:0]     shAmt;

    // Single-width result spread over Z with its sign in the upper half
    function automatic logic [2*DataWidth-1:0] widen(input logic [DataWidth-1:0] word);
        logic [DataWidth-1:0] upper;
        upper = {DataWidth{word[DataWidth-1]}};
        return {upper, word};
    endfunction

    assign op = aluOpE'(aluOp);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= busData; // Operand A for the next step
        end
    end

    // Operands sign extended for the full-width product
    assign aExt  = {{DataWidth{yReg[DataWidth-1]}}, yReg};
    assign bExt  = {{DataWidth{busData[DataWidth-1]}}, busData};
    assign shAmt = busData[ShiftBits-1:0];

    always_comb begin
        case (op)
            opAdd: begin
                aluResult = widen(yReg + busData);
            end
            opSub: begin
                aluResult = widen(yReg - busData);
            end
            opAnd: begin
                aluResult = widen(yReg & busData);
            end
            opOr: begin
                aluResult = widen(yReg | busData);
            end
            opShl: begin
                aluResult = widen(yReg << shAmt);
            end
            opShr: begin
                aluResult = widen($signed(yReg) >>> shAmt);
            end
            opNeg: begin
                aluResult = widen(-busData);
            end
            opNot: begin
                aluResult = widen(~busData);
            end
            opInc: begin
                aluResult = widen(busData + DataWidth'(1)); // Y is not used here
            end
            opMul: begin
                aluResult = aExt * bExt;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= aluResult;
        end
    end

    assign zHigh = zReg[2*DataWidth-1:DataWidth];
    assign zLow  = zReg[DataWidth-1:0];

endmodule

`default_nettype wire

// File: rtl/busSelector.sv
`timescale 1ns/1ps
`default_nettype none

module busSelector #(
    parameter int DataWidth = 32,
    parameter int RegCount  = datapathPkg::RegCount
) (
    input  wire logic [datapathPkg::SrcCount-1:0]   outSel,   // One-hot, or zero for an idle bus
    input  wire logic [RegCount-1:0][DataWidth-1:0] regValues,
    input  wire logic [DataWidth-1:0]               hiValue,
    input  wire logic [DataWidth-1:0]               loValue,
    input  wire logic [DataWidth-1:0]               zHigh,
    input  wire logic [DataWidth-1:0]               zLow,
    input  wire logic [DataWidth-1:0]               pcValue,
    input  wire logic [DataWidth-1:0]               mdrValue,
    input  wire logic [DataWidth-1:0]               inPortValue,
    input  wire logic [DataWidth-1:0]               irValue,
    output logic      [DataWidth-1:0]               busData
);

    import datapathPkg::*;

    localparam int IdxWidth = $clog2(SrcCount);

    logic [DataWidth-1:0] srcValues [SrcCount];
    logic [IdxWidth-1:0]  selIdx;
    logic                 selValid;

    // Source table in out-strobe order
    always_comb begin
        for (int r = 0; r < RegCount; r++) begin
            srcValues[srcR0 + r] = regValues[r];
        end
        srcValues[srcHi]     = hiValue;
        srcValues[srcLo]     = loValue;
        srcValues[srcZHigh]  = zHigh;
        srcValues[srcZLow]   = zLow;
        srcValues[srcPc]     = pcValue;
        srcValues[srcMdr]    = mdrValue;
        srcValues[srcInPort] = inPortValue;
        srcValues[srcIr]     = irValue;
    end

    // Highest set strobe wins when more than one is set
    always_comb begin
        selIdx   = '0;
        selValid = 1'b0;
        for (int i = 0; i < SrcCount; i++) begin
            if (outSel[i]) begin
                selIdx   = IdxWidth'(i);
                selValid = 1'b1;
            end
        end
    end

    assign busData = selValid ? srcValues[selIdx] : '0;

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int DataWidth = 32
) (
    input  wire logic                             Clock,
    input  wire logic                             rstN,
    input  wire logic [datapathPkg::RegCount-1:0] regIn,
    input  wire logic                             hiIn,
    input  wire logic                             loIn,
    input  wire logic                             pcIn,
    input  wire logic                             irIn,
    input  wire logic                             marIn,
    input  wire logic                             mdrIn,
    input  wire logic                             yIn,
    input  wire logic                             zIn,
    input  wire logic [datapathPkg::SrcCount-1:0] outSel,
    input  wire logic                             memRead,
    input  wire logic [DataWidth-1:0]             memDataIn,
    input  wire logic [DataWidth-1:0]             inPortData,
    input  wire datapathPkg::aluOpE               aluOp,
    output logic      [DataWidth-1:0]             busData,
    output logic      [DataWidth-1:0]             marValue,
    output logic      [DataWidth-1:0]             irValue
);

    import datapathPkg::*;

    logic [RegCount-1:0][DataWidth-1:0] regValues;
    logic [DataWidth-1:0]               hiValue;
    logic [DataWidth-1:0]               loValue;
    logic [DataWidth-1:0]               pcValue;
    logic [DataWidth-1:0]               mdrValue;
    logic [DataWidth-1:0]               inPortValue;
    logic [DataWidth-1:0]               zHigh;
    logic [DataWidth-1:0]               zLow;
    logic [AluOpWidth-1:0]              aluCode;

    assign aluCode = aluOp; // Plain code into the ALU stage

    // Input side
    memoryInterface #(.DataWidth(DataWidth)) i_memIf (
        .Clock(Clock), .rstN(rstN),
        .marIn(marIn), .mdrIn(mdrIn), .memRead(memRead),
        .busData(busData), .memDataIn(memDataIn), .inPortData(inPortData),
        .marValue(marValue), .mdrValue(mdrValue), .inPortValue(inPortValue)
    );

    registerBank #(.DataWidth(DataWidth), .RegCount(RegCount)) i_regBank (
        .Clock(Clock), .rstN(rstN), .busData(busData),
        .regIn(regIn), .hiIn(hiIn), .loIn(loIn), .pcIn(pcIn), .irIn(irIn),
        .regValues(regValues), .hiValue(hiValue), .loValue(loValue),
        .pcValue(pcValue), .irValue(irValue)
    );

    aluStage #(.DataWidth(DataWidth)) i_alu (
        .Clock(Clock), .rstN(rstN), .busData(busData),
        .yIn(yIn), .zIn(zIn), .aluOp(aluCode),
        .zHigh(zHigh), .zLow(zLow)
    );

    // Sole driver of the shared bus
    busSelector #(.DataWidth(DataWidth), .RegCount(RegCount)) i_busSel (
        .outSel(outSel), .regValues(regValues),
        .hiValue(hiValue), .loValue(loValue), .zHigh(zHigh), .zLow(zLow),
        .pcValue(pcValue), .mdrValue(mdrValue), .inPortValue(inPortValue),
        .irValue(irValue), .busData(busData)
    );

endmodule

`default_nettype wire

// File: rtl/datapathPkg.sv
`default_nettype none

package datapathPkg;

    localparam int AluOpWidth = 4;

    typedef enum logic [AluOpWidth-1:0] {
        opAdd = 4'd0,
        opSub = 4'd1,
        opAnd = 4'd2,
        opOr  = 4'd3,
        opShl = 4'd4,
        opShr = 4'd5, // Arithmetic
        opNeg = 4'd6,
        opNot = 4'd7,
        opInc = 4'd8, // Bus plus one, used in fetch
        opMul = 4'd9  // Signed, double width
    } aluOpE;

    localparam int RegCount = 16;

    // Positions in the out-strobe vector
    localparam int srcR0     = 0;
    localparam int srcR1     = 1;
    localparam int srcR2     = 2;
    localparam int srcR3     = 3;
    localparam int srcR4     = 4;
    localparam int srcR5     = 5;
    localparam int srcR6     = 6;
    localparam int srcR7     = 7;
    localparam int srcR8     = 8;
    localparam int srcR9     = 9;
    localparam int srcR10    = 10;
    localparam int srcR11    = 11;
    localparam int srcR12    = 12;
    localparam int srcR13    = 13;
    localparam int srcR14    = 14;
    localparam int srcR15    = 15;
    localparam int srcHi     = 16;
    localparam int srcLo     = 17;
    localparam int srcZHigh  = 18;
    localparam int srcZLow   = 19;
    localparam int srcPc     = 20;
    localparam int srcMdr    = 21;
    localparam int srcInPort = 22;
    localparam int srcIr     = 23;
    localparam int SrcCount  = 24;

endpackage

`default_nettype wire

// File: rtl/memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memoryInterface #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Clock,
    input  wire logic                 rstN,
    input  wire logic                 marIn,
    input  wire logic                 mdrIn,
    input  wire logic                 memRead,   // MDR takes memory data instead of the bus
    input  wire logic [DataWidth-1:0] busData,
    input  wire logic [DataWidth-1:0] memDataIn,
    input  wire logic [DataWidth-1:0] inPortData,
    output logic      [DataWidth-1:0] marValue,
    output logic      [DataWidth-1:0] mdrValue,
    output logic      [DataWidth-1:0] inPortValue
);

    logic [DataWidth-1:0] mdrSource;

    // Read path from memory or a write value from the bus
    assign mdrSource = memRead ? memDataIn : busData;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            marValue <= '0;
        end else if (marIn) begin
            marValue <= busData; // Address held for memory
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdrSource;
        end
    end

    // Port is sampled every cycle so the bus sees it one cycle late
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            inPortValue <= '0;
        end else begin
            inPortValue <= inPortData;
        end
    end

endmodule

`default_nettype wire

// File: rtl/registerBank.sv
`timescale 1ns/1ps
`default_nettype none

module registerBank #(
    parameter int DataWidth = 32,
    parameter int RegCount  = datapathPkg::RegCount
) (
    input  wire logic                                Clock,
    input  wire logic                                rstN,
    input  wire logic [DataWidth-1:0]                busData,
    input  wire logic [RegCount-1:0]                 regIn,   // One load strobe per register
    input  wire logic                                hiIn,
    input  wire logic                                loIn,
    input  wire logic                                pcIn,
    input  wire logic                                irIn,
    output logic      [RegCount-1:0][DataWidth-1:0]  regValues,
    output logic      [DataWidth-1:0]                hiValue,
    output logic      [DataWidth-1:0]                loValue,
    output logic      [DataWidth-1:0]                pcValue,
    output logic      [DataWidth-1:0]                irValue
);

    // General registers, R0 included, all load the same bus value
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            regValues <= '0;
        end else begin
            for (int r = 0; r < RegCount; r++) begin
                if (regIn[r]) begin
                    regValues[r] <= busData;
                end
            end
        end
    end

    // HI and LO hold the two halves of a product
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (hiIn) begin
                hiValue <= busData;
            end
            if (loIn) begin
                loValue <= busData;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcValue <= '0;
        end else if (pcIn) begin
            pcValue <= busData; // Incremented PC comes back through Z
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            irValue <= '0;
        end else if (irIn) begin
            irValue <= busData;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module datapathTb -o datapathSim
./obj_dir/datapathSim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
